// File: loopPkg.sv
/*
  Widths, register map and the shared error scaling rule of the carrier loop.
  Register addresses are byte addresses of 32-bit words, the low two bits are ignored.
*/
package loopPkg;

    localparam int errorWidth = 12;
    localparam int accumWidth = 40;
    localparam int freqWidth  = 32;
    localparam int expWidth   = 5;
    localparam int addrWidth  = 8;
    localparam int dataWidth  = 32;
    localparam int ctrlWidth  = 14;
    localparam int clearBit   = 31;

    // Register map
    localparam logic [addrWidth-1:0] regControl    = 8'h00;
    localparam logic [addrWidth-1:0] regUpperLimit = 8'h04;
    localparam logic [addrWidth-1:0] regLowerLimit = 8'h08;
    localparam logic [addrWidth-1:0] regSweepRate  = 8'h0C;
    localparam logic [addrWidth-1:0] regCenterFreq = 8'h10;
    localparam logic [addrWidth-1:0] regStatus     = 8'h14;
    localparam logic [addrWidth-1:0] regLagAccum   = 8'h18;

    typedef enum logic [1:0] {
        sweepOff  = 2'd0,
        sweepUp   = 2'd1,
        sweepDown = 2'd2
    } sweepState_t;

    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } axiResp_t;

    // Gain g scales the error by 2**(g-3), gain 0 gives zero
    function automatic logic signed [accumWidth-1:0] scaleError(
        input logic signed [errorWidth-1:0] err,
        input logic [expWidth-1:0]          gain
    );
        logic signed [accumWidth-1:0] errExt;
        errExt = {{(accumWidth-errorWidth){err[errorWidth-1]}}, err};
        case (gain)
            expWidth'(0): return '0;
            expWidth'(1): return errExt >>> 2;
            expWidth'(2): return errExt >>> 1;
            default:      return errExt <<< (gain - expWidth'(3));
        endcase
    endfunction

endpackage

// File: loopCfgIf.sv
/*
  Loop configuration from the register block to the filter and the NCO.
  clearAccum is a single-cycle pulse.
*/
`timescale 1ns/100ps

interface loopCfgIf;
    import loopPkg::*;

    logic [expWidth-1:0]         lagExp;
    logic [expWidth-1:0]         leadExp;
    logic [1:0]                  acqTrackControl;
    logic                        track;
    logic                        sweepEnable;
    logic signed [freqWidth-1:0] upperLimit;
    logic signed [freqWidth-1:0] lowerLimit;
    logic [freqWidth-1:0]        sweepRateMag;
    logic [freqWidth-1:0]        centerFreq;
    logic                        clearAccum;

    modport regs (
        output lagExp, leadExp, acqTrackControl, track, sweepEnable,
               upperLimit, lowerLimit, sweepRateMag, centerFreq, clearAccum
    );

    modport lag (
        input lagExp, acqTrackControl, track, sweepEnable,
              upperLimit, lowerLimit, sweepRateMag, clearAccum
    );

    modport nco (input leadExp, centerFreq);

endinterface

// File: loopRegs.sv
/*
  AXI4-Lite slave for the loop configuration and status.
  Unmapped addresses and writes to read-only registers answer SLVERR.
  Bit 31 of the control word is a self-clearing accumulator clear and reads as zero.
*/
`timescale 1ns/100ps

module loopRegs (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [loopPkg::addrWidth-1:0]          awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [loopPkg::dataWidth-1:0]          wdata,
    input  logic [loopPkg::dataWidth/8-1:0]        wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output loopPkg::axiResp_t                      bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [loopPkg::addrWidth-1:0]          araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [loopPkg::dataWidth-1:0]          rdata,
    output loopPkg::axiResp_t                      rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    loopCfgIf.regs                                 cfg,
    input  logic signed [loopPkg::accumWidth-1:0]  lagAccum,
    input  logic                                   hitUpper,
    input  logic                                   hitLower,
    input  loopPkg::sweepState_t                   sweepState
);
    import loopPkg::*;

    logic                   writeFire;
    logic                   readFire;
    logic [addrWidth-1:0]   wAddr;
    logic [addrWidth-1:0]   rAddr;
    logic [ctrlWidth-1:0]   controlReg;

    function automatic logic [dataWidth-1:0] merge(
        input logic [dataWidth-1:0]   oldValue,
        input logic [dataWidth-1:0]   newValue,
        input logic [dataWidth/8-1:0] strb
    );
        logic [dataWidth-1:0] result;
        result = oldValue;
        for (int i = 0; i < dataWidth/8; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = newValue[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Address and data are taken together, only while no response is pending
    assign writeFire = awvalid && wvalid && !bvalid;
    assign awready   = writeFire;
    assign wready    = writeFire;
    assign arready   = !rvalid;
    assign readFire  = arvalid && arready;

    assign wAddr = {awaddr[addrWidth-1:2], 2'b00};
    assign rAddr = {araddr[addrWidth-1:2], 2'b00};

    assign cfg.sweepEnable     = controlReg[0];
    assign cfg.track           = controlReg[1];
    assign cfg.acqTrackControl = controlReg[3:2];
    assign cfg.lagExp          = controlReg[8:4];
    assign cfg.leadExp         = controlReg[13:9];

    always_ff @(posedge clk) begin
        if (reset) begin
            controlReg       <= '0;
            cfg.upperLimit   <= {1'b0, {(freqWidth-1){1'b1}}};
            cfg.lowerLimit   <= {1'b1, {(freqWidth-1){1'b0}}};
            cfg.sweepRateMag <= '0;
            cfg.centerFreq   <= '0;
            cfg.clearAccum   <= 1'b0;
            bvalid           <= 1'b0;
        end else begin
            cfg.clearAccum <= 1'b0;
            if (writeFire) begin
                bvalid <= 1'b1;
                bresp  <= respOkay;
                case (wAddr)
                    regControl: begin
                        controlReg     <= ctrlWidth'(merge(dataWidth'(controlReg), wdata, wstrb));
                        cfg.clearAccum <= wstrb[clearBit/8] && wdata[clearBit];
                    end
                    regUpperLimit: cfg.upperLimit   <= merge(cfg.upperLimit, wdata, wstrb);
                    regLowerLimit: cfg.lowerLimit   <= merge(cfg.lowerLimit, wdata, wstrb);
                    regSweepRate:  cfg.sweepRateMag <= merge(cfg.sweepRateMag, wdata, wstrb);
                    regCenterFreq: cfg.centerFreq   <= merge(cfg.centerFreq, wdata, wstrb);
                    default:       bresp            <= respSlvErr;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (readFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Status and accumulator are sampled at the address handshake
    always_ff @(posedge clk) begin
        if (readFire) begin
            rresp <= respOkay;
            case (rAddr)
                regControl:    rdata <= dataWidth'(controlReg);
                regUpperLimit: rdata <= cfg.upperLimit;
                regLowerLimit: rdata <= cfg.lowerLimit;
                regSweepRate:  rdata <= cfg.sweepRateMag;
                regCenterFreq: rdata <= cfg.centerFreq;
                regStatus:     rdata <= dataWidth'({sweepState, hitLower, hitUpper});
                regLagAccum:   rdata <= lagAccum[accumWidth-1 -: dataWidth];
                default: begin
                    rdata <= '0;
                    rresp <= respSlvErr;
                end
            endcase
        end
    end

endmodule

// File: lagGain12.sv
/*
  Lag integrator with gain shift, tracking bandwidth reduction, sweep and limit clamp.
  Limits are compared against the top 32 accumulator bits and need upper >= lower,
  otherwise the accumulator holds. The sweep offset is added at the accumulator LSB.
*/
`timescale 1ns/100ps

module lagGain12 (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   clkEn,
    input  logic signed [loopPkg::errorWidth-1:0]  error,
    input  logic                                   carrierInSync,
    loopCfgIf.lag                                  cfg,
    output logic signed [loopPkg::accumWidth-1:0]  lagAccum,
    output logic                                   hitUpper,
    output logic                                   hitLower,
    output loopPkg::sweepState_t                   sweepState
);
    import loopPkg::*;

    localparam int fracWidth = accumWidth - freqWidth;

    logic [expWidth:0]              lagSum;
    logic [expWidth-1:0]            lagGain;
    logic signed [accumWidth-1:0]   lagError;
    logic                           sweepingUp;
    logic signed [freqWidth-1:0]    sweepOffset;
    logic signed [freqWidth-1:0]    negRate;
    logic signed [accumWidth:0]     sum;
    logic signed [freqWidth:0]      sumTop;

    // Lag gain goes with the square of the loop bandwidth, so the reduction counts twice
    assign lagSum  = {1'b0, cfg.lagExp} - {{(expWidth-2){1'b0}}, cfg.acqTrackControl, 1'b0};
    assign negRate = -cfg.sweepRateMag;

    always_ff @(posedge clk) begin
        if (!cfg.track) begin
            lagGain <= cfg.lagExp;
        end else if (lagSum[expWidth]) begin
            lagGain <= expWidth'(1);
        end else begin
            lagGain <= lagSum[expWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lagError <= '0;
        end else if (clkEn) begin
            lagError <= scaleError(error, lagGain);
        end
    end

    // Sweep direction flips on the hit flag and is remembered while in sync
    always_ff @(posedge clk) begin
        if (reset || !cfg.sweepEnable) begin
            sweepState  <= sweepOff;
            sweepOffset <= '0;
            sweepingUp  <= 1'b1;
        end else if (clkEn) begin
            case (sweepState)
                sweepOff: begin
                    if (!carrierInSync) begin
                        sweepState  <= sweepingUp ? sweepUp : sweepDown;
                        sweepOffset <= sweepingUp ? cfg.sweepRateMag : negRate;
                    end
                end
                sweepUp: begin
                    if (carrierInSync) begin
                        sweepState  <= sweepOff;
                        sweepOffset <= '0;
                        sweepingUp  <= 1'b1;
                    end else if (hitUpper) begin
                        sweepState  <= sweepDown;
                        sweepOffset <= negRate;
                    end else begin
                        sweepOffset <= cfg.sweepRateMag;
                    end
                end
                sweepDown: begin
                    if (carrierInSync) begin
                        sweepState  <= sweepOff;
                        sweepOffset <= '0;
                        sweepingUp  <= 1'b0;
                    end else if (hitLower) begin
                        sweepState  <= sweepUp;
                        sweepOffset <= cfg.sweepRateMag;
                    end else begin
                        sweepOffset <= negRate;
                    end
                end
                default: begin
                    sweepState  <= sweepOff;
                    sweepOffset <= '0;
                end
            endcase
        end
    end

    // One guard bit so an overflowing sum still compares correctly
    assign sum = {lagAccum[accumWidth-1], lagAccum}
               + {lagError[accumWidth-1], lagError}
               + {{(accumWidth+1-freqWidth){sweepOffset[freqWidth-1]}}, sweepOffset};
    assign sumTop = sum[accumWidth:fracWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
            hitUpper <= 1'b0;
            hitLower <= 1'b0;
        end else if (cfg.clearAccum) begin
            lagAccum <= '0;
        end else if (clkEn) begin
            hitUpper <= 1'b0;
            hitLower <= 1'b0;
            if (cfg.upperLimit >= cfg.lowerLimit) begin
                if (sumTop >= cfg.upperLimit) begin
                    lagAccum <= {cfg.upperLimit, {fracWidth{1'b0}}};
                    hitUpper <= 1'b1;
                end else if (sumTop <= cfg.lowerLimit) begin
                    lagAccum <= {cfg.lowerLimit, {fracWidth{1'b1}}};
                    hitLower <= 1'b1;
                end else begin
                    lagAccum <= sum[accumWidth-1:0];
                end
            end
        end
    end

endmodule

// File: leadGain.sv
/*
  Proportional path. The scaled error is added to the lag accumulator and the
  top 32 bits of the sum form the filter output, which wraps on overflow.
*/
`timescale 1ns/100ps

module leadGain (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   clkEn,
    input  logic signed [loopPkg::errorWidth-1:0]  error,
    input  logic signed [loopPkg::accumWidth-1:0]  lagAccum,
    loopCfgIf.nco                                  cfg,
    output logic signed [loopPkg::freqWidth-1:0]   filterOut,
    output logic                                   filterUpdate
);
    import loopPkg::*;

    logic signed [accumWidth-1:0] sum;

    assign sum = lagAccum + scaleError(error, cfg.leadExp);

    always_ff @(posedge clk) begin
        if (reset) begin
            filterOut    <= '0;
            filterUpdate <= 1'b0;
        end else begin
            // Tells the NCO that a new output is in place
            filterUpdate <= clkEn;
            if (clkEn) begin
                filterOut <= sum[accumWidth-1 -: freqWidth];
            end
        end
    end

endmodule

// File: carrierNco.sv
/*
  Carrier NCO. Phase advances by centerFreq plus the filter output once per
  filter update and wraps modulo 2**32.
*/
`timescale 1ns/100ps

module carrierNco (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  filterUpdate,
    input  logic signed [loopPkg::freqWidth-1:0]  filterOut,
    loopCfgIf.nco                                 cfg,
    output logic [loopPkg::freqWidth-1:0]         ncoPhase,
    output logic [loopPkg::freqWidth-1:0]         ncoFreq
);
    import loopPkg::*;

    logic [freqWidth-1:0] freqSum;

    assign freqSum = cfg.centerFreq + filterOut;

    always_ff @(posedge clk) begin
        if (reset) begin
            ncoFreq  <= '0;
            ncoPhase <= '0;
        end else if (filterUpdate) begin
            ncoFreq  <= freqSum;
            ncoPhase <= ncoPhase + freqSum;
        end
    end

endmodule

// File: carrierLoopTop.sv
/*
  Carrier tracking loop filter and NCO with an AXI4-Lite control port.
  errorValid qualifies each phase error sample and there is no back-pressure.
*/
`timescale 1ns/100ps

module carrierLoopTop (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [loopPkg::addrWidth-1:0]          awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [loopPkg::dataWidth-1:0]          wdata,
    input  logic [loopPkg::dataWidth/8-1:0]        wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output loopPkg::axiResp_t                      bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [loopPkg::addrWidth-1:0]          araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [loopPkg::dataWidth-1:0]          rdata,
    output loopPkg::axiResp_t                      rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    input  logic signed [loopPkg::errorWidth-1:0]  error,
    input  logic                                   errorValid,
    input  logic                                   carrierInSync,
    output logic [loopPkg::freqWidth-1:0]          ncoFreq,
    output logic [loopPkg::freqWidth-1:0]          ncoPhase
);
    import loopPkg::*;

    logic signed [accumWidth-1:0]  lagAccum;
    logic                          hitUpper;
    logic                          hitLower;
    sweepState_t                   sweepState;
    logic signed [freqWidth-1:0]   filterOut;
    logic                          filterUpdate;

    loopCfgIf cfg ();

    loopRegs loopRegs_inst (.*);

    lagGain12 lagGain12_inst (
        .clkEn (errorValid),
        .*
    );

    leadGain leadGain_inst (
        .clkEn (errorValid),
        .*
    );

    carrierNco carrierNco_inst (.*);

endmodule

// File: tbClock.sv
/*
  Free-running testbench clock with an 8 ns period, starting low.
*/
`timescale 1ns/100ps

module tbClock (
    output logic clk
);
    localparam time halfPeriod = 4ns;

    initial begin
        clk = 1'b0;
    end

    always begin
        #halfPeriod;
        clk = ~clk;
    end

endmodule

// File: tbCarrierLoop.sv
/*
  Directed testbench for carrierLoopTop with its own model of the lag, lead and NCO rules.
  The sweep test checks the ramp and reversal rules directly instead of the model.
*/
`timescale 1ns/100ps

module tbCarrierLoop;
    import loopPkg::*;

    localparam int maxWait = 50;

    logic                clk;
    logic                reset;
    logic [7:0]          awaddr;
    logic                awvalid;
    logic                awready;
    logic [31:0]         wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    axiResp_t            bresp;
    logic                bvalid;
    logic                bready;
    logic [7:0]          araddr;
    logic                arvalid;
    logic                arready;
    logic [31:0]         rdata;
    axiResp_t            rresp;
    logic                rvalid;
    logic                rready;
    logic signed [11:0]  error;
    logic                errorValid;
    logic                carrierInSync;
    logic [31:0]         ncoFreq;
    logic [31:0]         ncoPhase;

    // Reference model state
    logic signed [39:0]  mAccum;
    logic signed [39:0]  mLagErr;
    logic [31:0]         mFilter;
    logic [31:0]         mFreq;
    logic [31:0]         mCenter;
    logic signed [31:0]  mUpper;
    logic signed [31:0]  mLower;
    logic                mHitUpper;
    logic                mHitLower;
    int                  mLagGain;
    int                  mLeadExp;
    int                  errorCount;
    logic                timedOut;

    tbClock clockGen (.clk(clk));

    carrierLoopTop carrierLoopTop_inst (.*);

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        timedOut = 1'b1;
    endtask

    // Gain g multiplies by 2**(g-3) with floor rounding, gain 0 blocks the path
    function automatic longint scaled(input logic signed [11:0] e, input int g);
        if (g == 0) begin
            return 0;
        end
        return (longint'(e) <<< g) >>> 3;
    endfunction

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output axiResp_t resp);
        int waited;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(awready && wready) && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) reportTimeout("write address and data handshake");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!bvalid) reportTimeout("write response");
        resp = bresp;
        @(posedge clk);
        #1;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output axiResp_t resp);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) reportTimeout("read address handshake");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!rvalid) reportTimeout("read data");
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        axiResp_t resp;
        axiWrite(addr, data, resp);
        if (resp != respOkay) reportError($sformatf("write to %h answered %0d", addr, resp));
        case (addr)
            regUpperLimit: mUpper = data;
            regLowerLimit: mLower = data;
            regCenterFreq: mCenter = data;
            default: ;
        endcase
    endtask

    task automatic writeControl(input logic sweep, input logic trk, input int acq,
                                input int lagE, input int leadE, input logic clear);
        logic [31:0] word;
        int          diff;
        word = {clear, 17'd0, leadE[4:0], lagE[4:0], acq[1:0], trk, sweep};
        writeReg(regControl, word);
        diff      = lagE - 2 * acq;
        mLagGain  = !trk ? lagE : (diff < 0 ? 1 : diff);
        mLeadExp  = leadE;
        if (clear) mAccum = '0;
    endtask

    task automatic readCheck(input logic [7:0] addr, input logic [31:0] exp,
                             input string what);
        logic [31:0] data;
        axiResp_t    resp;
        axiRead(addr, data, resp);
        if (resp != respOkay) reportError($sformatf("%s read answered %0d", what, resp));
        if (data !== exp) reportError($sformatf("%s read %h expected %h", what, data, exp));
    endtask

    // Lead output uses the accumulator before this sample is integrated
    task automatic sendSample(input logic signed [11:0] e);
        longint sum;
        longint lead;
        error      = e;
        errorValid = 1'b1;
        @(posedge clk);
        lead      = longint'(mAccum) + scaled(e, mLeadExp);
        mFilter   = lead[39:8];
        sum       = longint'(mAccum) + longint'(mLagErr);
        mHitUpper = 1'b0;
        mHitLower = 1'b0;
        if ((sum >>> 8) >= longint'(mUpper)) begin
            mAccum    = {mUpper, 8'h00};
            mHitUpper = 1'b1;
        end else if ((sum >>> 8) <= longint'(mLower)) begin
            mAccum    = {mLower, 8'hFF};
            mHitLower = 1'b1;
        end else begin
            mAccum = sum[39:0];
        end
        mLagErr = 40'(scaled(e, mLagGain));
        mFreq   = mCenter + mFilter;
        #1;
        errorValid = 1'b0;
    endtask

    task automatic runBurst(input int count);
        for (int i = 0; i < count; i++) begin
            sendSample(12'($urandom));
        end
    endtask

    task automatic checkLoop(input string what);
        readCheck(regLagAccum, mAccum[39:8], what);
        if (ncoFreq !== mFreq) reportError($sformatf("%s ncoFreq %h expected %h",
                                                     what, ncoFreq, mFreq));
    endtask

    task automatic testRegisterAccess();
        logic [31:0] values [5];
        logic [31:0] data;
        axiResp_t    resp;
        for (int i = 0; i < 5; i++) begin
            values[i] = (i == 0) ? ($urandom & 32'h3FFF) : $urandom;
            writeReg(8'(4 * i), values[i]);
        end
        for (int i = 0; i < 5; i++) begin
            readCheck(8'(4 * i), values[i], "register readback");
        end
        readCheck(regStatus, 32'h0, "idle status");
        axiWrite(8'h20, 32'h1234, resp);
        if (resp != respSlvErr) reportError("unmapped write did not answer SLVERR");
        axiRead(8'h1C, data, resp);
        if (resp != respSlvErr) reportError("unmapped read did not answer SLVERR");
        writeReg(regUpperLimit, 32'h7FFF_FFFF);
        writeReg(regLowerLimit, 32'h8000_0000);
        writeReg(regSweepRate, 32'h0);
        writeReg(regCenterFreq, 32'h0);
        writeControl(1'b0, 1'b0, 0, 0, 0, 1'b1);
    endtask

    task automatic testLagGain();
        int lagList [5] = '{0, 1, 2, 5, 9};
        foreach (lagList[i]) begin
            writeControl(1'b0, 1'b0, 0, lagList[i], 0, 1'b0);
            runBurst(8);
            checkLoop($sformatf("lagExp %0d", lagList[i]));
        end
        // Tracking with lagExp 5 walks the gain down to 1 and then hits the floor
        for (int acq = 0; acq < 4; acq++) begin
            writeControl(1'b0, 1'b1, acq, 5, 0, 1'b0);
            runBurst(8);
            checkLoop($sformatf("track acq %0d", acq));
        end
    endtask

    task automatic testLeadNco();
        logic [31:0] prevPhase;
        writeReg(regCenterFreq, $urandom);
        writeControl(1'b0, 1'b0, 0, 6, 7, 1'b0);
        runBurst(10);
        checkLoop("lead path");
        prevPhase = ncoPhase;
        sendSample(12'($urandom));
        @(posedge clk);
        #1;
        if (ncoFreq !== mFreq) reportError($sformatf("ncoFreq %h expected %h", ncoFreq, mFreq));
        if (ncoPhase !== prevPhase + mFreq) begin
            reportError("ncoPhase did not advance by ncoFreq");
        end
    endtask

    task automatic testClamp();
        int count;
        writeReg(regUpperLimit, 32'h0000_4000);
        writeReg(regLowerLimit, 32'hFFFF_C000);
        writeControl(1'b0, 1'b0, 0, 14, 0, 1'b0);
        count = 0;
        while (!mHitUpper && count < 40) begin
            sendSample(12'sd2047);
            count++;
        end
        readCheck(regLagAccum, 32'h0000_4000, "upper clamp");
        readCheck(regStatus, 32'h1, "upper status");
        count = 0;
        while (!mHitLower && count < 40) begin
            sendSample(-12'sd2048);
            count++;
        end
        readCheck(regLagAccum, 32'hFFFF_C000, "lower clamp");
        readCheck(regStatus, 32'h2, "lower status");
        checkLoop("clamped output");
        writeReg(regUpperLimit, 32'h7FFF_FFFF);
        writeReg(regLowerLimit, 32'h8000_0000);
    endtask

    task automatic testSweep();
        logic [31:0] value;
        logic [31:0] status;
        axiResp_t    resp;
        int          acc;
        int          prev;
        int          dir;
        logic        sawUpper;
        logic        sawLower;
        // Zero gain flushes the lag error before the ramp starts
        writeControl(1'b0, 1'b0, 0, 0, 0, 1'b0);
        sendSample(12'sd0);
        writeReg(regUpperLimit, 32'd36);
        writeReg(regLowerLimit, -32'sd36);
        writeReg(regSweepRate, 32'h800);
        writeControl(1'b0, 1'b0, 0, 0, 0, 1'b1);
        carrierInSync = 1'b0;
        writeControl(1'b1, 1'b0, 0, 0, 0, 1'b0);
        prev     = 0;
        dir      = 1;
        sawUpper = 1'b0;
        sawLower = 1'b0;
        for (int i = 0; i < 30; i++) begin
            sendSample(12'sd0);
            axiRead(regLagAccum, value, resp);
            axiRead(regStatus, status, resp);
            acc = value;
            if (status[3:2] == sweepOff) reportError("sweep state off while out of sync");
            if (acc == 36) begin
                if (!status[0]) reportError("hitUpper not set at the upper limit");
                sawUpper = 1'b1;
                dir      = -1;
            end else if (acc == -36) begin
                if (!status[1]) reportError("hitLower not set at the lower limit");
                sawLower = sawUpper;
                dir      = 1;
            end else if (i > 0 && acc != prev + 8 * dir) begin
                reportError($sformatf("sweep sample %0d gave %0d after %0d", i, acc, prev));
            end
            prev = acc;
        end
        if (!sawUpper || !sawLower) reportError("sweep did not reverse at both limits");
        carrierInSync = 1'b1;
        sendSample(12'sd0);
        axiRead(regLagAccum, value, resp);
        for (int i = 0; i < 3; i++) begin
            sendSample(12'sd0);
            readCheck(regLagAccum, value, "accumulator held in sync");
        end
        readCheck(regStatus, 32'h0, "sweep stopped in sync");
        writeControl(1'b0, 1'b0, 0, 0, 0, 1'b1);
        writeReg(regUpperLimit, 32'h7FFF_FFFF);
        writeReg(regLowerLimit, 32'h8000_0000);
        writeReg(regSweepRate, 32'h0);
    endtask

    task automatic testClear();
        writeControl(1'b0, 1'b1, 1, 6, 3, 1'b0);
        runBurst(6);
        checkLoop("before clear");
        writeControl(1'b0, 1'b1, 1, 6, 3, 1'b1);
        readCheck(regLagAccum, 32'h0, "cleared accumulator");
        readCheck(regControl, 32'h666, "control kept over clear");
        runBurst(4);
        checkLoop("after clear");
    endtask

    initial begin
        wait (timedOut);
        $display("Closing counts: %0d errors, 1 timeout", errorCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hd596c190));
        errorCount    = 0;
        timedOut      = 1'b0;
        reset         = 1'b1;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = 4'hF;
        wvalid        = 1'b0;
        bready        = 1'b1;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b1;
        error         = '0;
        errorValid    = 1'b0;
        carrierInSync = 1'b0;
        mAccum        = '0;
        mLagErr       = '0;
        mFilter       = '0;
        mFreq         = '0;
        mCenter       = '0;
        mUpper        = 32'h7FFF_FFFF;
        mLower        = 32'h8000_0000;
        mHitUpper     = 1'b0;
        mHitLower     = 1'b0;
        mLagGain      = 0;
        mLeadExp      = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        testRegisterAccess();
        testLagGain();
        testLeadNco();
        testClamp();
        testSweep();
        testClear();
        $display("Closing counts: %0d errors, 0 timeouts", errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
loopPkg.sv
loopCfgIf.sv
loopRegs.sv
lagGain12.sv
leadGain.sv
carrierNco.sv
carrierLoopTop.sv
tbClock.sv
tbCarrierLoop.sv

// File: Makefile
# Verilator build and run of the carrier loop testbench

all: run

build:
	verilator --binary --timing -f vlog.f --top-module tbCarrierLoop -o simCarrierLoop

run: build
	./obj_dir/simCarrierLoop | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only loopPkg.sv loopCfgIf.sv loopRegs.sv lagGain12.sv \
		leadGain.sv carrierNco.sv carrierLoopTop.sv --top-module carrierLoopTop

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
